// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_mat_chain
FLIST    := flist.f
BUILD    := obj_dir
SIM_BIN  := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := Simulation passed

SRCS     := $(shell grep -v '^+' $(FLIST))
HDRS     := $(wildcard verification/*.svh)

.PHONY: all run check clean

all: check

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

$(LOG): $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true

# always reruns the simulation
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

# reruns only when the binary is newer than the log
check: $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (grep "^\[FAIL\]\|timeout" $(LOG); exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/mat_fixed_pkg.sv
package mat_fixed_pkg;

    //--------------------------------------------------------------------------
    // number format
    //--------------------------------------------------------------------------
    localparam int FRAC_BITS = 13;                  // Q12.13
    localparam int SAMPLE_W  = 26;
    localparam int ACC_W     = 52;                  // full width of a product sum
    localparam int LANES     = 4;
    localparam int DIM       = 4;                   // rows and columns per matrix

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;      // wraps, no saturation

    //--------------------------------------------------------------------------
    // matrix containers, first field sits in the msbs
    //--------------------------------------------------------------------------
    typedef struct packed {
        sample_t c1;
        sample_t c2;
        sample_t c3;
        sample_t c4;
    } row_t;

    typedef struct packed {
        row_t r1;
        row_t r2;
        row_t r3;
        row_t r4;
    } mat4_t;

    typedef struct packed {
        mat4_t l1;                                  // lane 0
        mat4_t l2;
        mat4_t l3;
        mat4_t l4;                                  // lane 3
    } mat_set_t;

endpackage

// File: common/mat_seq_pkg.sv
package mat_seq_pkg;

    //--------------------------------------------------------------------------
    // sequencing limits
    //--------------------------------------------------------------------------
    localparam int PASS_MAX   = 8;
    localparam int PASS_W     = 4;                  // holds 0 to 8
    localparam int PASS_IDX_W = $clog2(PASS_MAX);   // bank address bits
    localparam int LANE_W     = $clog2(mat_fixed_pkg::LANES);

    typedef logic [PASS_W-1:0] pass_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        MUL  = 2'd1,
        FEED = 2'd2,
        DONE = 2'd3
    } seq_state_t;

    //--------------------------------------------------------------------------
    // requests
    //--------------------------------------------------------------------------
    typedef struct packed {
        pass_t                   passes;            // 0 runs as 1
        mat_fixed_pkg::mat_set_t in_set;
    } job_t;

    typedef struct packed {
        pass_t                pass;                 // 0-based
        logic [LANE_W-1:0]    lane;
        mat_fixed_pkg::mat4_t mat;
    } wr_req_t;

endpackage

// File: flist.f
+incdir+verification
common/mat_fixed_pkg.sv
common/mat_seq_pkg.sv
mat_mul/mat_mul4.sv
weight_bank/weight_bank.sv
verilog/operand_reg.sv
verilog/pass_counter.sv
verilog/mat_chain_fsm.sv
verilog/mat_chain_top.sv
verification/tb_mat_chain.sv

// File: mat_mul/mat_mul4.sv
`timescale 1ns/1ps

module mat_mul4 (
    input  logic                    clk_mul,
    input  logic                    rst_n,
    input  logic                    en_mul,
    input  mat_fixed_pkg::mat_set_t w_set,
    input  mat_fixed_pkg::mat_set_t x_set,
    output mat_fixed_pkg::mat_set_t p_set
);

    // element view of one matrix, index 0 is r1 / c1
    typedef mat_fixed_pkg::sample_t [0:mat_fixed_pkg::DIM-1][0:mat_fixed_pkg::DIM-1] el_mat_t;

    el_mat_t [0:mat_fixed_pkg::LANES-1] w_el;       // lane 0 is l1
    el_mat_t [0:mat_fixed_pkg::LANES-1] x_el;
    el_mat_t [0:mat_fixed_pkg::LANES-1] p_el;

    assign w_el = w_set;
    assign x_el = x_set;

    //--------------------------------------------------------------------------
    // one multiply-accumulate tree per output element
    //--------------------------------------------------------------------------
    for (genvar l = 0; l < mat_fixed_pkg::LANES; l++) begin : g_lane
        for (genvar r = 0; r < mat_fixed_pkg::DIM; r++) begin : g_row
            for (genvar c = 0; c < mat_fixed_pkg::DIM; c++) begin : g_col
                mat_fixed_pkg::acc_t sum;
                mat_fixed_pkg::acc_t acc_q;

                // row r of the weight times column c of the operand
                always_comb begin
                    sum = '0;
                    for (int k = 0; k < mat_fixed_pkg::DIM; k++) begin
                        sum = sum + mat_fixed_pkg::acc_t'(w_el[l][r][k])
                                  * mat_fixed_pkg::acc_t'(x_el[l][k][c]);
                    end
                end

                always_ff @(posedge clk_mul) begin
                    if (!rst_n) begin
                        acc_q <= '0;
                    end else if (en_mul) begin
                        acc_q <= sum;                   // holds between passes
                    end
                end

                // Q26 product back to Q13, plain truncation of both ends
                assign p_el[l][r][c] =
                    acc_q[mat_fixed_pkg::FRAC_BITS +: mat_fixed_pkg::SAMPLE_W];
            end
        end
    end

    assign p_set = p_el;

endmodule

// File: verification/tb_mat_chain_model.svh
`ifndef TB_MAT_CHAIN_MODEL_SVH
`define TB_MAT_CHAIN_MODEL_SVH

//----------------------------------------------------------------------------
// chain model, the first field of every struct sits in the msbs
//----------------------------------------------------------------------------
localparam int SW = mat_fixed_pkg::SAMPLE_W;
localparam int MW = $bits(mat_fixed_pkg::mat4_t);
localparam int EL = mat_fixed_pkg::DIM * mat_fixed_pkg::DIM;    // elements per matrix

mat_fixed_pkg::mat4_t shadow_w [mat_seq_pkg::PASS_MAX][mat_fixed_pkg::LANES];   // bank copy

function automatic mat_fixed_pkg::sample_t elem_at(mat_fixed_pkg::mat4_t m, int r, int c);
    logic [MW-1:0] v;
    v = m;
    return v[(EL - 1 - (r * mat_fixed_pkg::DIM + c)) * SW +: SW];
endfunction

function automatic mat_fixed_pkg::mat4_t lane_of(mat_fixed_pkg::mat_set_t s, int l);
    wide_t v;
    v = s;
    return v[(mat_fixed_pkg::LANES - 1 - l) * MW +: MW];
endfunction

// w times x, summed at 52 bits and cut back to Q13
function automatic mat_fixed_pkg::mat4_t mat_product(mat_fixed_pkg::mat4_t w,
                                                     mat_fixed_pkg::mat4_t x);
    logic [MW-1:0]       v;
    mat_fixed_pkg::acc_t acc;
    v = '0;
    for (int r = 0; r < mat_fixed_pkg::DIM; r++) begin
        for (int c = 0; c < mat_fixed_pkg::DIM; c++) begin
            acc = '0;
            for (int k = 0; k < mat_fixed_pkg::DIM; k++) begin
                acc = acc + mat_fixed_pkg::acc_t'(elem_at(w, r, k))
                          * mat_fixed_pkg::acc_t'(elem_at(x, k, c));
            end
            v[(EL - 1 - (r * mat_fixed_pkg::DIM + c)) * SW +: SW] =
                acc[mat_fixed_pkg::FRAC_BITS +: SW];           // bits 38 to 13
        end
    end
    return v;
endfunction

function automatic mat_fixed_pkg::mat_set_t chain_model(mat_fixed_pkg::mat_set_t in_set,
                                                        int n);
    wide_t                v;
    mat_fixed_pkg::mat4_t x;
    for (int l = 0; l < mat_fixed_pkg::LANES; l++) begin
        x = lane_of(in_set, l);
        for (int p = 0; p < n; p++) begin
            x = mat_product(shadow_w[p][l], x);
        end
        v[(mat_fixed_pkg::LANES - 1 - l) * MW +: MW] = x;
    end
    return v;
endfunction

function automatic mat_fixed_pkg::mat_set_t negate_set(mat_fixed_pkg::mat_set_t s);
    wide_t v;
    v = s;
    for (int i = 0; i < mat_fixed_pkg::LANES * EL; i++) begin
        v[i * SW +: SW] = -v[i * SW +: SW];                // wraps like the datapath
    end
    return v;
endfunction

function automatic mat_fixed_pkg::mat4_t diag_mat(mat_fixed_pkg::sample_t d);
    logic [MW-1:0] v;
    v = '0;
    for (int i = 0; i < mat_fixed_pkg::DIM; i++) begin
        v[(EL - 1 - i * (mat_fixed_pkg::DIM + 1)) * SW +: SW] = d;
    end
    return v;
endfunction

`endif

// File: verification/tb_mat_chain.sv
`timescale 1ns/1ps

module tb_mat_chain;

    localparam int JOB_TIMEOUT = 4 * mat_seq_pkg::PASS_MAX + 8;   // cycles from start to done

    typedef logic [$bits(mat_fixed_pkg::mat_set_t)-1:0] wide_t;

    logic                    clk_mul;
    logic                    rst_n;
    logic                    wr_en;
    mat_seq_pkg::wr_req_t    wr_req;
    logic                    start;
    mat_seq_pkg::job_t       job;
    logic                    busy;
    logic                    done;
    mat_fixed_pkg::mat_set_t result;
    int                      errors;
    int                      checks;

    `include "tb_mat_chain_model.svh"

    mat_chain_top UUT (
        .clk_mul (clk_mul),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_req  (wr_req),
        .start   (start),
        .job     (job),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    initial begin
        clk_mul = 1'b0;
        forever #2 clk_mul = ~clk_mul;
    end

    task automatic check_value(input string name, input wide_t expected, input wide_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    //------------------------------------------------------------------------
    // stimulus helpers
    //------------------------------------------------------------------------
    function automatic mat_fixed_pkg::sample_t rand_sample();
        logic [31:0] r;
        r = $urandom;
        if (r[31:29] == 3'b000) begin
            return r[SW-1:0];                                  // full range, wraps often
        end
        return mat_fixed_pkg::sample_t'($signed(r[15:0]));     // within +-4.0
    endfunction

    function automatic mat_fixed_pkg::mat4_t rand_mat();
        logic [MW-1:0] v;
        for (int i = 0; i < EL; i++) begin
            v[i * SW +: SW] = rand_sample();
        end
        return v;
    endfunction

    function automatic mat_fixed_pkg::mat_set_t rand_set();
        return {rand_mat(), rand_mat(), rand_mat(), rand_mat()};
    endfunction

    task automatic write_weight(input int pass_no, input int lane_no,
                                input mat_fixed_pkg::mat4_t m);
        @(posedge clk_mul);
        wr_en       <= 1'b1;
        wr_req.pass <= mat_seq_pkg::pass_t'(pass_no);
        wr_req.lane <= lane_no[mat_seq_pkg::LANE_W-1:0];
        wr_req.mat  <= m;
        @(posedge clk_mul);
        wr_en <= 1'b0;
        shadow_w[pass_no][lane_no] = m;
    endtask

    // kind 0 random, 1 identity, 2 negated identity
    task automatic fill_bank(input int kind);
        mat_fixed_pkg::mat4_t m;
        for (int p = 0; p < mat_seq_pkg::PASS_MAX; p++) begin
            for (int l = 0; l < mat_fixed_pkg::LANES; l++) begin
                case (kind)
                    1: m = diag_mat(mat_fixed_pkg::sample_t'(1 << mat_fixed_pkg::FRAC_BITS));
                    2: m = diag_mat(-mat_fixed_pkg::sample_t'(1 << mat_fixed_pkg::FRAC_BITS));
                    default: m = rand_mat();
                endcase
                write_weight(p, l, m);
            end
        end
    endtask

    task automatic check_idle(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk_mul);
            check_value({name, " busy"}, '0, wide_t'(busy));
            check_value({name, " done"}, '0, wide_t'(done));
            check_value({name, " result"}, '0, result);
        end
    endtask

    //------------------------------------------------------------------------
    // one job from start to the cycle after done
    //------------------------------------------------------------------------
    task automatic run_job(input string name, input int passes,
                           input mat_fixed_pkg::mat_set_t in_set,
                           input mat_fixed_pkg::mat_set_t expected, input bit extra_start);
        int n;
        int cyc;
        bit seen;
        n = (passes == 0) ? 1 : passes;
        @(posedge clk_mul);
        start      <= 1'b1;
        job.passes <= mat_seq_pkg::pass_t'(passes);
        job.in_set <= in_set;
        @(posedge clk_mul);                                    // start accepted here
        start <= 1'b0;
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < JOB_TIMEOUT) begin
            @(negedge clk_mul);
            check_value({name, " busy"}, wide_t'(1'b1), wide_t'(busy));
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk_mul);
                cyc++;
                if (extra_start && cyc == 1) begin
                    start      <= 1'b1;                        // other job, must be dropped
                    job.passes <= mat_seq_pkg::pass_t'(1);
                    job.in_set <= rand_set();
                end else begin
                    start <= 1'b0;
                end
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: job %s gave no done within %0d cycles", name, JOB_TIMEOUT);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Simulation failed");
            $finish;
        end else begin
            check_value({name, " done delay"}, wide_t'(2 * n - 1), wide_t'(cyc));
            for (int l = 0; l < mat_fixed_pkg::LANES; l++) begin
                check_value($sformatf("%s lane %0d", name, l), wide_t'(lane_of(expected, l)),
                            wide_t'(lane_of(result, l)));
            end
            @(posedge clk_mul);
            start <= 1'b0;
            @(negedge clk_mul);
            check_value({name, " done width"}, '0, wide_t'(done));
            check_value({name, " busy after done"}, '0, wide_t'(busy));
            check_value({name, " result hold"}, expected, result);
        end
    endtask

    initial begin
        mat_fixed_pkg::mat_set_t in_set;
        int n;
        int p;
        int l;
        errors = 0;
        checks = 0;
        void'($urandom(94));
        rst_n  = 1'b0;
        wr_en  = 1'b0;
        wr_req = '0;
        start  = 1'b0;
        job    = '0;
        for (int i = 0; i < mat_seq_pkg::PASS_MAX; i++) begin
            for (int j = 0; j < mat_fixed_pkg::LANES; j++) begin
                shadow_w[i][j] = '0;                           // bank clears at reset
            end
        end
        repeat (8) @(posedge clk_mul);
        rst_n <= 1'b1;

        check_idle("after reset", 4);
        fill_bank(0);
        check_idle("after bank load", 2);

        for (int j = 0; j < 4; j++) begin
            in_set = rand_set();
            run_job($sformatf("single %0d", j), 1, in_set, chain_model(in_set, 1), 1'b0);
        end
        for (int j = 0; j < 40; j++) begin
            n      = 1 + ($urandom % mat_seq_pkg::PASS_MAX);
            in_set = rand_set();
            run_job($sformatf("chain %0d n=%0d", j, n), n, in_set, chain_model(in_set, n),
                    1'b0);
        end

        // start pulses while busy, and a zero pass count
        in_set = rand_set();
        run_job("zero passes", 0, in_set, chain_model(in_set, 1), 1'b1);
        in_set = rand_set();
        run_job("start while busy", 5, in_set, chain_model(in_set, 5), 1'b1);

        // fraction alignment
        fill_bank(1);
        in_set = rand_set();
        run_job("identity", 3, in_set, in_set, 1'b0);
        fill_bank(2);
        in_set = rand_set();
        run_job("neg identity", 1, in_set, negate_set(in_set), 1'b0);
        in_set = rand_set();
        run_job("neg identity twice", 2, in_set, in_set, 1'b0);

        for (int j = 0; j < 4; j++) begin
            p = $urandom % mat_seq_pkg::PASS_MAX;
            l = $urandom % mat_fixed_pkg::LANES;
            write_weight(p, l, rand_mat());
            in_set = rand_set();
            run_job($sformatf("rewrite %0d pass %0d lane %0d", j, p, l), 8, in_set,
                    chain_model(in_set, 8), 1'b0);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/mat_chain_fsm.sv
`timescale 1ns/1ps

module mat_chain_fsm (
    input  logic clk_mul,
    input  logic rst_n,
    input  logic start,
    input  logic last,
    output logic load_in,
    output logic load_fb,
    output logic en_mul,
    output logic cnt_clr,
    output logic cnt_inc,
    output logic busy,
    output logic done
);

    mat_seq_pkg::seq_state_t state_q;
    mat_seq_pkg::seq_state_t state_d;
    logic                    accept;

    assign accept = start && (state_q == mat_seq_pkg::IDLE);   // start dropped while busy

    //--------------------------------------------------------------------------
    // next state
    //--------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            mat_seq_pkg::IDLE: begin
                if (accept) begin
                    state_d = mat_seq_pkg::MUL;
                end
            end
            mat_seq_pkg::MUL: begin
                state_d = last ? mat_seq_pkg::DONE : mat_seq_pkg::FEED;
            end
            mat_seq_pkg::FEED: begin
                state_d = mat_seq_pkg::MUL;
            end
            default: begin
                state_d = mat_seq_pkg::IDLE;        // DONE lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk_mul) begin
        if (!rst_n) begin
            state_q <= mat_seq_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //--------------------------------------------------------------------------
    // output decode
    //--------------------------------------------------------------------------
    assign load_in = accept;                        // operands and count latch at E0
    assign cnt_clr = accept;
    assign en_mul  = (state_q == mat_seq_pkg::MUL);
    assign load_fb = (state_q == mat_seq_pkg::FEED);
    assign cnt_inc = (state_q == mat_seq_pkg::FEED);    // next weight with the fed-back product
    assign busy    = (state_q != mat_seq_pkg::IDLE);
    assign done    = (state_q == mat_seq_pkg::DONE);

endmodule

// File: verilog/mat_chain_top.sv
`timescale 1ns/1ps

module mat_chain_top (
    input  logic                    clk_mul,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  mat_seq_pkg::wr_req_t    wr_req,
    input  logic                    start,
    input  mat_seq_pkg::job_t       job,
    output logic                    busy,
    output logic                    done,
    output mat_fixed_pkg::mat_set_t result
);

    logic                    load_in;
    logic                    load_fb;
    logic                    en_mul;
    logic                    cnt_clr;
    logic                    cnt_inc;
    logic                    last;
    mat_seq_pkg::pass_t      pass_idx;
    mat_fixed_pkg::mat_set_t w_set;
    mat_fixed_pkg::mat_set_t x_set;

    //--------------------------------------------------------------------------
    // control
    //--------------------------------------------------------------------------
    mat_chain_fsm u_fsm (
        .clk_mul (clk_mul),
        .rst_n   (rst_n),
        .start   (start),
        .last    (last),
        .load_in (load_in),
        .load_fb (load_fb),
        .en_mul  (en_mul),
        .cnt_clr (cnt_clr),
        .cnt_inc (cnt_inc),
        .busy    (busy),
        .done    (done)
    );

    pass_counter u_cnt (
        .clk_mul  (clk_mul),
        .rst_n    (rst_n),
        .cnt_clr  (cnt_clr),
        .cnt_inc  (cnt_inc),
        .passes   (job.passes),
        .pass_idx (pass_idx),
        .last     (last)
    );

    //--------------------------------------------------------------------------
    // datapath
    //--------------------------------------------------------------------------
    weight_bank u_bank (
        .clk_mul  (clk_mul),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_req   (wr_req),
        .pass_idx (pass_idx),
        .w_set    (w_set)
    );

    operand_reg u_opnd (
        .clk_mul (clk_mul),
        .rst_n   (rst_n),
        .load_in (load_in),
        .load_fb (load_fb),
        .in_set  (job.in_set),
        .p_set   (result),                          // product loops back here
        .x_set   (x_set)
    );

    mat_mul4 u_mul (
        .clk_mul (clk_mul),
        .rst_n   (rst_n),
        .en_mul  (en_mul),
        .w_set   (w_set),
        .x_set   (x_set),
        .p_set   (result)
    );

endmodule

// File: verilog/operand_reg.sv
`timescale 1ns/1ps

module operand_reg (
    input  logic                    clk_mul,
    input  logic                    rst_n,
    input  logic                    load_in,
    input  logic                    load_fb,
    input  mat_fixed_pkg::mat_set_t in_set,
    input  mat_fixed_pkg::mat_set_t p_set,
    output mat_fixed_pkg::mat_set_t x_set
);

    // running right-hand operand of the chain
    always_ff @(posedge clk_mul) begin
        if (!rst_n) begin
            x_set <= '0;
        end else if (load_in) begin
            x_set <= in_set;                        // fresh job
        end else if (load_fb) begin
            x_set <= p_set;                         // previous pass result
        end
    end

endmodule

// File: verilog/pass_counter.sv
`timescale 1ns/1ps

module pass_counter (
    input  logic               clk_mul,
    input  logic               rst_n,
    input  logic               cnt_clr,
    input  logic               cnt_inc,
    input  mat_seq_pkg::pass_t passes,
    output mat_seq_pkg::pass_t pass_idx,
    output logic               last
);

    mat_seq_pkg::pass_t cnt_q;                      // latched pass count
    mat_seq_pkg::pass_t cnt_d;

    // zero runs one pass, anything above the bank depth runs the full bank
    always_comb begin
        if (passes == '0) begin
            cnt_d = mat_seq_pkg::pass_t'(1);
        end else if (passes > mat_seq_pkg::pass_t'(mat_seq_pkg::PASS_MAX)) begin
            cnt_d = mat_seq_pkg::pass_t'(mat_seq_pkg::PASS_MAX);
        end else begin
            cnt_d = passes;
        end
    end

    always_ff @(posedge clk_mul) begin
        if (!rst_n) begin
            pass_idx <= '0;
            cnt_q    <= '0;
        end else if (cnt_clr) begin
            pass_idx <= '0;
            cnt_q    <= cnt_d;
        end else if (cnt_inc) begin
            pass_idx <= pass_idx + mat_seq_pkg::pass_t'(1);
        end
    end

    assign last = (pass_idx == cnt_q - mat_seq_pkg::pass_t'(1));

endmodule

// File: weight_bank/weight_bank.sv
`timescale 1ns/1ps

module weight_bank (
    input  logic                    clk_mul,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  mat_seq_pkg::wr_req_t    wr_req,
    input  mat_seq_pkg::pass_t      pass_idx,
    output mat_fixed_pkg::mat_set_t w_set
);

    mat_fixed_pkg::mat4_t bank [mat_seq_pkg::PASS_MAX][mat_fixed_pkg::LANES];

    mat_fixed_pkg::mat4_t [0:mat_fixed_pkg::LANES-1] rd_lanes;   // lane 0 lands in l1
    logic [mat_seq_pkg::PASS_IDX_W-1:0]               wr_sel;
    logic [mat_seq_pkg::PASS_IDX_W-1:0]               rd_sel;
    logic                                             wr_hit;

    // writes past the last pass are dropped
    assign wr_hit = wr_en && (wr_req.pass < mat_seq_pkg::pass_t'(mat_seq_pkg::PASS_MAX));
    assign wr_sel = wr_req.pass[mat_seq_pkg::PASS_IDX_W-1:0];
    assign rd_sel = pass_idx[mat_seq_pkg::PASS_IDX_W-1:0];   // counter stays below PASS_MAX

    always_ff @(posedge clk_mul) begin
        if (!rst_n) begin
            for (int p = 0; p < mat_seq_pkg::PASS_MAX; p++) begin
                for (int l = 0; l < mat_fixed_pkg::LANES; l++) begin
                    bank[p][l] <= '0;
                end
            end
        end else if (wr_hit) begin
            bank[wr_sel][wr_req.lane] <= wr_req.mat;
        end
    end

    //--------------------------------------------------------------------------
    // read side, all lanes of one pass, no latency
    //--------------------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < mat_fixed_pkg::LANES; l++) begin
            rd_lanes[l] = bank[rd_sel][l];
        end
    end

    assign w_set = rd_lanes;

endmodule
